/* Bender.yml */
package:
  name: node_mem

sources:
  - hw/node_pkg.sv
  - hw/node_byte_ram.sv
  - hw/node_addr_decode.sv
  - hw/node_mem_access.sv
  - hw/node_rsp_queue.sv
  - hw/node_mem_top.sv
  - target: simulation
    files:
      - tb/tb_node_mem.sv

/* tb.f */
hw/node_pkg.sv
hw/node_byte_ram.sv
hw/node_addr_decode.sv
hw/node_mem_access.sv
hw/node_rsp_queue.sv
hw/node_mem_top.sv
tb/tb_node_mem.sv

/* tb/tb_node_mem.sv */
`timescale 1ns/100ps

module tb_node_mem import node_pkg::*; ();

// ============================================================
// Run length
// ============================================================
localparam int CLK_HALF   = 10;  // 20 ns period
localparam int RESET_CYC  = 4;
localparam int TABLE_LEN  = 13;  // Directed entries
localparam int BP_REQS    = 4;   // Requests sent while credits are withheld
localparam int FILL_REQS  = 16;  // Preload of words 0 to 7 in both regions
localparam int RAND_REQS  = 20;
localparam int MAX_CYCLES = (TABLE_LEN + BP_REQS + FILL_REQS + RAND_REQS) * 20 + 500;

// One directed step with the answer worked out by hand
typedef struct packed {
	logic              we;
	logic [SEL_W-1:0]  sel;
	logic [31:0]       addr;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] exp_rdata;
	logic              exp_err;
} entry_t;

logic     clk = 1'b0;
logic     reset;
logic     req_valid;
mem_req_t req;
logic     req_credit;
logic     rsp_valid;
mem_rsp_t rsp;
logic     rsp_credit;

entry_t            stim_table [TABLE_LEN];
logic [DATA_W-1:0] shared_model [SHARED_WORDS];   // Reference copy of shared RAM
logic [DATA_W-1:0] scratch_model [SCRATCH_WORDS]; // Reference copy of the scratchpad
mem_rsp_t          exp_q [$];                     // Responses still owed, in issue order
logic [31:0]       lfsr_state = 32'hc5a7;
logic [TAG_W-1:0]  next_tag;
bit                hold_credits;     // Consumer keeps response credits back
int                req_credits;      // Request credits held by the testbench
int                pending_credits;  // Response credits not yet handed back
int                rsp_count;
int                credit_pulses;
int                errors;
int                tests;
int                failed_tests;
int                test_err0;        // Error count when the current test began
int                cycle_count;
string             cur_test;

node_mem_top node_mem_top_inst (
	.clk_i        (clk),
	.reset_i      (reset),
	.req_valid_i  (req_valid),
	.req_i        (req),
	.req_credit_o (req_credit),
	.rsp_valid_o  (rsp_valid),
	.rsp_o        (rsp),
	.rsp_credit_i (rsp_credit)
);

always #CLK_HALF clk = ~clk;

// Hard stop if the DUT never finishes the traffic
always @(posedge clk) begin
	cycle_count++;
	if (cycle_count >= MAX_CYCLES) begin
		$display("run stopped after %0d cycles with %0d responses still owed",
			cycle_count, exp_q.size());
		$display("Regression failed");
		$finish;
	end
end

// ============================================================
// Checks and bookkeeping
// ============================================================
task automatic compare_rsp(input string name, input mem_rsp_t got, input mem_rsp_t want);
	if (got !== want) begin  // X in the model must show as X in the DUT too
		errors++;
		$display("error %s rdata %h err %h tag %h expected rdata %h err %h tag %h",
			name, got.rdata, got.err, got.tag, want.rdata, want.err, want.tag);
	end
endtask

task automatic compare_count(input string name, input int got, input int want);
	if (got != want) begin
		errors++;
		$display("error %s got %0h expected %0h", name, got, want);
	end
endtask

task automatic begin_test(input string name);
	cur_test  = name;
	test_err0 = errors;
endtask

task automatic end_test();
	tests++;
	if (errors == test_err0)
		$display("test %s ok", cur_test);
	else begin
		failed_tests++;
		$display("test %s failed with %0d errors", cur_test, errors - test_err0);
	end
endtask

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One step per bit, bits shifted in from the low end
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		v          = {v[30:0], lfsr_state[0]};
	end
	return v;
endfunction

// ============================================================
// Reference model of both regions
// ============================================================
task automatic model_apply(input mem_req_t r, output mem_rsp_t want);
	logic [DATA_W-1:0] word;
	int                idx;
	want     = '0;
	want.tag = r.tag;
	idx      = int'(r.addr.fields.offset_field >> 2);  // Byte offset to word index
	word     = '0;
	case (r.addr.fields.region_field)
	REGION_SHARED:  word = shared_model[idx % SHARED_WORDS];
	REGION_SCRATCH: word = scratch_model[idx % SCRATCH_WORDS];
	default:        want.err = 1'b1;  // Unmapped, nothing is touched
	endcase
	if (!want.err && r.we) begin
		for (int b = 0; b < SEL_W; b++)
			if (r.sel[b])
				word[b*8 +: 8] = r.wdata[b*8 +: 8];  // Only selected lanes change
		if (r.addr.fields.region_field == REGION_SHARED)
			shared_model[idx % SHARED_WORDS] = word;
		else
			scratch_model[idx % SCRATCH_WORDS] = word;
	end else if (!want.err)
		want.rdata = word;  // Writes answer with zero
endtask

// ============================================================
// Cycle driver
// ============================================================

// Advances to the next falling edge, where outputs are settled from the last rise
task automatic tick();
	@(negedge clk);
	req_valid = 1'b0;  // A request lasts exactly one cycle
	// Request credit goes back in the same cycle as the response
	compare_count("req_credit_o", int'(req_credit === 1'b1), int'(rsp_valid === 1'b1));
	if (rsp_valid === 1'b1) begin
		rsp_count++;
		pending_credits++;
		if (exp_q.size() == 0) begin
			errors++;
			$display("response with tag %h came back with no request outstanding", rsp.tag);
		end else
			compare_rsp("rsp_o", rsp, exp_q.pop_front());
	end
	if (req_credit === 1'b1) begin
		credit_pulses++;
		req_credits++;
	end
	rsp_credit = 1'b0;
	if (!hold_credits && pending_credits > 0) begin
		rsp_credit = 1'b1;  // One credit back per cycle
		pending_credits--;
	end
endtask

task automatic send_req(input mem_req_t r, input mem_rsp_t want);
	tick();
	while (req_credits == 0)
		tick();  // No credit, no request
	req       = r;
	req_valid = 1'b1;
	req_credits--;
	exp_q.push_back(want);
endtask

task automatic issue_modeled(input logic we, input logic [SEL_W-1:0] sel,
	input logic [31:0] addr, input logic [DATA_W-1:0] wdata, output mem_rsp_t want);
	mem_req_t r;
	r.we       = we;
	r.sel      = sel;
	r.addr.raw = addr;
	r.wdata    = wdata;
	r.tag      = next_tag;
	next_tag++;  // Wraps, at most four are in flight
	model_apply(r, want);
	send_req(r, want);
endtask

// Waits for every owed response, then expects all request credits home
task automatic drain();
	while (exp_q.size() != 0 || pending_credits != 0)
		tick();
	repeat (3) tick();
	compare_count("request credits after drain", req_credits, REQ_CREDITS);
endtask

task automatic run_table(input int first, input int last, input string name);
	mem_rsp_t want;
	mem_rsp_t hand;
	begin_test(name);
	for (int i = first; i <= last; i++) begin
		issue_modeled(stim_table[i].we, stim_table[i].sel, stim_table[i].addr,
			stim_table[i].wdata, want);
		hand = {stim_table[i].exp_rdata, stim_table[i].exp_err, want.tag};
		compare_rsp("reference model", want, hand);
	end
	drain();
	end_test();
endtask

// Region 0 at 0x0000_0000, region 1 at 0x0004_0000, the rest unmapped
task automatic load_table();
	stim_table[0]  = {1'b1, 4'hF, 32'h0000_0010, 32'hDEAD_BEEF, 32'h0000_0000, 1'b0};
	stim_table[1]  = {1'b0, 4'hF, 32'h0000_0010, 32'h0000_0000, 32'hDEAD_BEEF, 1'b0};
	stim_table[2]  = {1'b1, 4'hF, 32'h0004_0010, 32'h1122_3344, 32'h0000_0000, 1'b0};
	stim_table[3]  = {1'b1, 4'h5, 32'h0004_0010, 32'hAABB_CCDD, 32'h0000_0000, 1'b0};
	stim_table[4]  = {1'b1, 4'h8, 32'h0004_0011, 32'h7700_0000, 32'h0000_0000, 1'b0};
	stim_table[5]  = {1'b0, 4'h0, 32'h0004_0010, 32'h0000_0000, 32'h77BB_33DD, 1'b0};
	stim_table[6]  = {1'b0, 4'h0, 32'h0000_0010, 32'h0000_0000, 32'hDEAD_BEEF, 1'b0};
	stim_table[7]  = {1'b1, 4'hF, 32'h0008_0010, 32'hCAFE_F00D, 32'h0000_0000, 1'b1};
	stim_table[8]  = {1'b0, 4'hF, 32'hFFFC_0010, 32'h0000_0000, 32'h0000_0000, 1'b1};
	stim_table[9]  = {1'b0, 4'h0, 32'h0000_0010, 32'h0000_0000, 32'hDEAD_BEEF, 1'b0};
	stim_table[10] = {1'b0, 4'h0, 32'h0004_0010, 32'h0000_0000, 32'h77BB_33DD, 1'b0};
	stim_table[11] = {1'b1, 4'hF, 32'h0000_3FFC, 32'h0123_4567, 32'h0000_0000, 1'b0};
	stim_table[12] = {1'b0, 4'h0, 32'h0000_3FFC, 32'h0000_0000, 32'h0123_4567, 1'b0};
endtask

// ============================================================
// Test sequence
// ============================================================
initial begin
	mem_rsp_t          want;
	logic [31:0]       addr;
	logic [1:0]        pick;
	logic [SEL_W-1:0]  sel;
	logic              we;
	int                seen0;
	int                pulses0;
	reset           = 1'b1;
	req_valid       = 1'b0;
	req             = '0;
	rsp_credit      = 1'b0;
	hold_credits    = 1'b0;
	next_tag        = '0;
	req_credits     = REQ_CREDITS;
	pending_credits = 0;
	load_table();

	begin_test("reset");
	repeat (RESET_CYC) begin
		@(negedge clk);
		compare_count("rsp_valid_o in reset", int'(rsp_valid !== 1'b0), 0);
		compare_count("req_credit_o in reset", int'(req_credit !== 1'b0), 0);
	end
	reset = 1'b0;
	repeat (6) tick();
	compare_count("responses before first request", rsp_count, 0);
	compare_count("req_credit_o pulses before first request", credit_pulses, 0);
	end_test();

	run_table(0, 1, "shared full word");
	run_table(2, 6, "scratch byte lanes");
	run_table(7, 10, "unmapped region");
	run_table(11, 12, "shared last word");

	begin_test("response back-pressure");
	seen0        = rsp_count;
	pulses0      = credit_pulses;
	hold_credits = 1'b1;
	issue_modeled(1'b0, 4'hF, 32'h0000_0010, '0, want);
	issue_modeled(1'b0, 4'hF, 32'h0004_0010, '0, want);
	issue_modeled(1'b0, 4'hF, 32'h0010_0000, '0, want);
	issue_modeled(1'b0, 4'hF, 32'h0000_3FFC, '0, want);
	repeat (12) tick();  // Long enough for every response to reach the queue
	compare_count("responses while credits withheld", rsp_count - seen0, RSP_CREDITS);
	compare_count("req_credit_o pulses while credits withheld",
		credit_pulses - pulses0, rsp_count - seen0);
	hold_credits = 1'b0;
	drain();  // Tag order is enforced by the order of exp_q
	compare_count("responses after credits returned", rsp_count - seen0, BP_REQS);
	compare_count("req_credit_o pulses after credits returned", credit_pulses - pulses0, BP_REQS);
	end_test();

	begin_test("random traffic");
	for (int w = 0; w < FILL_REQS; w++) begin
		addr = {13'd0, w[3], 13'd0, w[2:0], 2'b00};  // Words 0 to 7 of both regions
		issue_modeled(1'b1, 4'hF, addr, addr ^ {addr[15:0], addr[31:16]} ^ 32'hA5C3_0000, want);
	end
	for (int n = 0; n < RAND_REQS; n++) begin
		we   = 1'(rand_bits(1));
		pick = 2'(rand_bits(2));
		case (pick)
		2'd0:    addr = 32'h0000_0000;
		2'd1:    addr = 32'h0004_0000;
		2'd2:    addr = 32'h0008_0000;  // Region 2, unmapped
		default: addr = 32'hFFFC_0000;  // Top region, unmapped
		endcase
		addr[4:0] = 5'(rand_bits(5));   // Word 0 to 7 and a byte offset
		sel       = SEL_W'(rand_bits(SEL_W));
		if (we && sel == '0)
			sel = 4'hF;
		issue_modeled(we, sel, addr, rand_bits(DATA_W), want);
	end
	drain();
	end_test();

	$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
	if (errors == 0)
		$display("Regression passed");
	else
		$display("Regression failed");
	$finish;
end

endmodule

/* hw/node_mem_top.sv */
`timescale 1ns/100ps

// Local memory side of one ring node
// Requests run through decode, memory access and an in-order response queue
module node_mem_top import node_pkg::*; (
	input  logic     clk_i,
	input  logic     reset_i,       // Synchronous, active high
	input  logic     req_valid_i,   // Requester spends one credit per pulse
	input  mem_req_t req_i,
	output logic     req_credit_o,  // Returns one request credit
	output logic     rsp_valid_o,   // Node spends one response credit per pulse
	output mem_rsp_t rsp_o,
	input  logic     rsp_credit_i   // Consumer returns one response credit
);

// ============================================================
// Stage to stage wiring
// ============================================================
logic       dec_valid;  // Decoded request is present for access
stage_req_t dec;        // Request with its region target
logic       acc_valid;  // Response word is ready to be queued
mem_rsp_t   acc;        // Response formed by the access stage

// Stage one registers the request and classifies the region
node_addr_decode node_addr_decode_inst (
	.clk_i       (clk_i),
	.reset_i     (reset_i),
	.req_valid_i (req_valid_i),
	.req_i       (req_i),
	.dec_valid_o (dec_valid),
	.dec_o       (dec)
);

// Stage two reads or writes the selected memory
node_mem_access node_mem_access_inst (
	.clk_i       (clk_i),
	.reset_i     (reset_i),
	.dec_valid_i (dec_valid),
	.dec_i       (dec),
	.acc_valid_o (acc_valid),
	.acc_o       (acc)
);

// Stage three holds responses in order until a credit lets them go
node_rsp_queue node_rsp_queue_inst (
	.clk_i        (clk_i),
	.reset_i      (reset_i),
	.acc_valid_i  (acc_valid),
	.acc_i        (acc),
	.rsp_valid_o  (rsp_valid_o),
	.rsp_o        (rsp_o),
	.rsp_credit_i (rsp_credit_i),
	.req_credit_o (req_credit_o)
);

// No stage stalls
// The request credits cap how many are in flight at the queue depth

endmodule

/* hw/node_rsp_queue.sv */
`timescale 1ns/100ps

// Third pipeline stage
// In-order response FIFO, deep enough for every request credit
// The head goes out while the node holds a response credit, and each
// response issued hands one request credit back to the requester
module node_rsp_queue import node_pkg::*; (
	input  logic     clk_i,
	input  logic     reset_i,
	input  logic     acc_valid_i,   // Push strobe from the access stage
	input  mem_rsp_t acc_i,
	output logic     rsp_valid_o,   // Head is issued this cycle
	output mem_rsp_t rsp_o,
	input  logic     rsp_credit_i,  // Consumer hands back one response credit
	output logic     req_credit_o   // One request credit back to the requester
);

mem_rsp_t            slot_q [REQ_CREDITS];  // Response storage
logic [PTR_W-1:0]    wr_ptr_q;              // Next slot to fill
logic [PTR_W-1:0]    rd_ptr_q;              // Current head
logic [FILL_W-1:0]   fill_q;                // Responses waiting
logic [CREDIT_W-1:0] credit_q;              // Response credits held by the node
logic                issue;                 // Head leaves at the next edge

// ============================================================
// Issue decision
// ============================================================
assign issue        = (fill_q != '0) && (credit_q != '0);
assign rsp_valid_o  = issue;
assign rsp_o        = slot_q[rd_ptr_q];     // Head is shown even while it waits
assign req_credit_o = issue;                // Same cycle as the response

// ============================================================
// Storage
// ============================================================
always_ff @(posedge clk_i) begin
	if (acc_valid_i)
		slot_q[wr_ptr_q] <= acc_i;
end

// ============================================================
// Pointers, fill level and response credits
// ============================================================
always_ff @(posedge clk_i) begin
	if (reset_i) begin
		wr_ptr_q <= '0;
		rd_ptr_q <= '0;
		fill_q   <= '0;
		credit_q <= CREDIT_W'(RSP_CREDITS);  // Node starts with all response credits
	end else begin
		if (acc_valid_i)
			wr_ptr_q <= wr_ptr_q + 1'b1;  // Depth is a power of two, pointer wraps itself
		if (issue)
			rd_ptr_q <= rd_ptr_q + 1'b1;
		case ({acc_valid_i, issue})
		2'b10:   fill_q <= fill_q + 1'b1;
		2'b01:   fill_q <= fill_q - 1'b1;
		default: fill_q <= fill_q;  // Push and pop together leave the level alone
		endcase
		// A credit may come back in the same cycle one is spent
		credit_q <= credit_q - CREDIT_W'(issue) + CREDIT_W'(rsp_credit_i);
	end
end

// ============================================================
// Checks
// ============================================================

// Request credits upstream keep the queue from ever overflowing
a_no_push_when_full: assert property (
	@(posedge clk_i) disable iff (reset_i)
	(fill_q == FILL_W'(REQ_CREDITS)) |-> !acc_valid_i
) else
	$error("response pushed into a full queue");

// The consumer never returns more credits than it was given
a_credit_bound: assert property (
	@(posedge clk_i) disable iff (reset_i)
	credit_q <= CREDIT_W'(RSP_CREDITS)
) else
	$error("response credit count above its reset value");

endmodule

/* hw/node_mem_access.sv */
`timescale 1ns/100ps

// Second pipeline stage
// Owns both memories, performs the read or write at the edge after decode and
// forms the response word in the following cycle
module node_mem_access import node_pkg::*; (
	input  logic       clk_i,
	input  logic       reset_i,
	input  logic       dec_valid_i,  // Decoded request present
	input  stage_req_t dec_i,
	output logic       acc_valid_o,  // Response word valid, pushed at the next edge
	output mem_rsp_t   acc_o
);

logic                  shared_en;      // Shared RAM selected this cycle
logic                  scratch_en;     // Scratchpad selected this cycle
logic [SEL_W-1:0]      lane_we;        // Select lanes gated by the write flag
logic [SHARED_AW-1:0]  shared_addr;    // Word index into shared RAM
logic [SCRATCH_AW-1:0] scratch_addr;   // Word index into scratchpad
logic [DATA_W-1:0]     shared_rdata;
logic [DATA_W-1:0]     scratch_rdata;
target_e               target_q;       // Target of the access now in flight
logic                  we_q;           // Access in flight was a write
logic [TAG_W-1:0]      tag_q;          // Tag of the access in flight

// ============================================================
// Memory selection
// ============================================================
assign shared_en  = dec_valid_i && (dec_i.target == TGT_SHARED);
assign scratch_en = dec_valid_i && (dec_i.target == TGT_SCRATCH);  // Unmapped enables nothing
assign lane_we    = dec_i.req.sel & {SEL_W{dec_i.req.we}};  // A read writes no lane

// Word index starts above the lane bits and is cut to each memory's depth
assign shared_addr  = dec_i.req.addr.fields.offset_field[WORD_LSB +: SHARED_AW];
assign scratch_addr = dec_i.req.addr.fields.offset_field[WORD_LSB +: SCRATCH_AW];

node_byte_ram #(.WORDS(SHARED_WORDS)) shared_ram_inst (
	.clk_i   (clk_i),
	.en_i    (shared_en),
	.we_i    (lane_we),
	.addr_i  (shared_addr),
	.wdata_i (dec_i.req.wdata),
	.rdata_o (shared_rdata)
);

node_byte_ram #(.WORDS(SCRATCH_WORDS)) scratch_ram_inst (
	.clk_i   (clk_i),
	.en_i    (scratch_en),
	.we_i    (lane_we),
	.addr_i  (scratch_addr),
	.wdata_i (dec_i.req.wdata),
	.rdata_o (scratch_rdata)
);

// ============================================================
// Side band delay, lines up with the memory read register
// ============================================================
always_ff @(posedge clk_i) begin
	if (reset_i)
		acc_valid_o <= 1'b0;
	else
		acc_valid_o <= dec_valid_i;
end

always_ff @(posedge clk_i) begin
	if (dec_valid_i) begin
		target_q <= dec_i.target;
		we_q     <= dec_i.req.we;
		tag_q    <= dec_i.req.tag;
	end
end

// Response word
// Reads return the chosen memory, writes and errors return zero
always_comb begin
	acc_o.tag   = tag_q;
	acc_o.err   = (target_q == TGT_NONE);  // Stands in for the missing network interface
	acc_o.rdata = '0;
	if (!we_q) begin
		case (target_q)
		TGT_SHARED:  acc_o.rdata = shared_rdata;
		TGT_SCRATCH: acc_o.rdata = scratch_rdata;
		default:     acc_o.rdata = '0;
		endcase
	end
end

endmodule

/* hw/node_addr_decode.sv */
`timescale 1ns/100ps

// First pipeline stage
// Captures the request at the edge where it is valid and maps its region field
// onto one of the memory targets
module node_addr_decode import node_pkg::*; (
	input  logic       clk_i,
	input  logic       reset_i,
	input  logic       req_valid_i,  // One-cycle request strobe
	input  mem_req_t   req_i,
	output logic       dec_valid_o,  // Decoded request present this cycle
	output stage_req_t dec_o         // Request plus its target
);

target_e target;  // Region class of the incoming address

// ============================================================
// Region decode
// ============================================================
always_comb begin
	case (req_i.addr.fields.region_field)
	REGION_SHARED:  target = TGT_SHARED;   // Shared RAM
	REGION_SCRATCH: target = TGT_SCRATCH;  // Private scratchpad
	default:        target = TGT_NONE;     // Nothing lives here, access will flag it
	endcase
end

// ============================================================
// Stage register
// ============================================================

// The valid bit is the only control state of this stage
always_ff @(posedge clk_i) begin
	if (reset_i)
		dec_valid_o <= 1'b0;
	else
		dec_valid_o <= req_valid_i;  // Exactly one cycle per request
end

// Payload is loaded only when a request arrives
always_ff @(posedge clk_i) begin
	if (req_valid_i) begin
		dec_o.req    <= req_i;
		dec_o.target <= target;
	end
end

// A write handed to the access stage always enables at least one byte lane,
// otherwise it would be acknowledged without touching memory
a_write_has_lanes: assert property (
	@(posedge clk_i) disable iff (reset_i)
	req_valid_i && req_i.we |=> (dec_o.req.sel != '0)
) else
	$error("write reached access with all byte lanes clear");

endmodule

/* hw/node_byte_ram.sv */
`timescale 1ns/100ps

// Single-port word memory with byte-lane writes
// Used for both the shared RAM and the scratchpad
// The read word appears one cycle after en_i, a write returns the old word
module node_byte_ram import node_pkg::*; #(
	parameter int WORDS = 1024  // Depth in words, any power of two
) (
	input  logic                     clk_i,
	input  logic                     en_i,     // Access strobe for this memory
	input  logic [SEL_W-1:0]         we_i,     // One write strobe per byte lane
	input  logic [$clog2(WORDS)-1:0] addr_i,   // Word index
	input  logic [DATA_W-1:0]        wdata_i,
	output logic [DATA_W-1:0]        rdata_o   // Registered read word
);

// ============================================================
// Storage
// ============================================================
logic [DATA_W-1:0] mem [WORDS];  // Whole words, lanes are written one by one

// Each lane is written on its own so partial selects merge with the old word
always_ff @(posedge clk_i) begin
	if (en_i) begin
		for (int i = 0; i < SEL_W; i++) begin
			if (we_i[i])
				mem[addr_i][i*LANE_W +: LANE_W] <= wdata_i[i*LANE_W +: LANE_W];
		end
	end
end

// ============================================================
// Read port
// ============================================================

// Output register holds its value between accesses
// The access stage only looks at it in the cycle after its own enable
always_ff @(posedge clk_i) begin
	if (en_i)
		rdata_o <= mem[addr_i];  // Read before write at the same index
end

endmodule

/* hw/node_pkg.sv */
package node_pkg;

// ============================================================
// Word and address layout
// ============================================================
localparam int DATA_W   = 32;              // Width of one data word
localparam int SEL_W    = 4;               // One select bit per byte lane
localparam int LANE_W   = DATA_W / SEL_W;  // Bits in one byte lane
localparam int REGION_W = 14;              // Address bits 31 to 18 pick the region
localparam int OFFSET_W = 18;              // Byte offset inside the region
localparam int TAG_W    = 4;               // Tag echoed back with the response
localparam int WORD_LSB = $clog2(SEL_W);   // First offset bit of the word index

// The two mapped regions, everything else is answered with an error
localparam logic [REGION_W-1:0] REGION_SHARED  = 14'd0;
localparam logic [REGION_W-1:0] REGION_SCRATCH = 14'd1;

// Memory depths in words and the matching index widths
localparam int SHARED_WORDS  = 4096;
localparam int SCRATCH_WORDS = 1024;
localparam int SHARED_AW     = $clog2(SHARED_WORDS);
localparam int SCRATCH_AW    = $clog2(SCRATCH_WORDS);

// ============================================================
// Credit flow
// ============================================================
localparam int REQ_CREDITS = 4;                        // Requester credits, also queue depth
localparam int RSP_CREDITS = 2;                        // Node credits for issuing responses
localparam int PTR_W       = $clog2(REQ_CREDITS);      // Queue slot pointer
localparam int FILL_W      = $clog2(REQ_CREDITS + 1);  // Queue occupancy from 0 to full
localparam int CREDIT_W    = $clog2(RSP_CREDITS + 1);  // Response credit count

// The same byte address read raw or split into region and offset
typedef union packed {
	logic [REGION_W+OFFSET_W-1:0] raw;
	struct packed {
		logic [REGION_W-1:0] region_field;  // Selects shared RAM, scratchpad or nothing
		logic [OFFSET_W-1:0] offset_field;  // Byte offset, low bits address the lane
	} fields;
} node_addr_u;

// Which memory a request lands in
typedef enum logic [1:0] {
	TGT_SHARED  = 2'd0,
	TGT_SCRATCH = 2'd1,
	TGT_NONE    = 2'd2  // Unmapped region
} target_e;

// Request as it enters the node
typedef struct packed {
	logic              we;     // Write when set, read otherwise
	logic [SEL_W-1:0]  sel;    // Byte lanes taking part in a write
	node_addr_u        addr;
	logic [DATA_W-1:0] wdata;
	logic [TAG_W-1:0]  tag;
} mem_req_t;

// Request after decode, carrying its target along
typedef struct packed {
	mem_req_t req;
	target_e  target;
} stage_req_t;

// Response returned to the requester
typedef struct packed {
	logic [DATA_W-1:0] rdata;  // Read word, zero for writes and errors
	logic              err;    // Set for an unmapped address
	logic [TAG_W-1:0]  tag;
} mem_rsp_t;

endpackage
